// File: hw/decodeFlagsIf.sv
// Unclocked flag bundle; every signal is combinational and valid only in the cycle of its word
`timescale 1ns/1ps

interface decodeFlagsIf;

	// Unit and flow classes
	logic flowCtrl;
	logic branch;
	logic jmp;
	logic alu;
	logic alu0Only;
	logic fpu;
	logic sync;

	// Memory access
	logic load;
	logic mem;
	logic memNdx;
	logic rmw;
	logic aq;
	logic rl;
	logic memdb;
	logic memsb;

	// Register file write
	logic rfw;
	logic preload;
	logic [decodePkg::LaneCount-1:0] laneWe;

	modport classSrc (output flowCtrl, branch, jmp, alu, alu0Only, fpu, sync, input memNdx);
	modport memSrc (output load, mem, memNdx, rmw, aq, rl, memdb, memsb);
	modport regSrc (output rfw, preload, laneWe, input load);
	modport sink (input flowCtrl, branch, jmp, alu, alu0Only, fpu, sync, load, mem, memNdx,
		rmw, aq, rl, memdb, memsb, rfw, preload, laneWe);

endinterface

// File: hw/decodeOutputReg.sv
// One register stage, new word every cycle with no stall; ConstWidth must be at least 30
`timescale 1ns/1ps

module decodeOutputReg #(
	parameter int ConstWidth = 64,
	parameter int TagWidth = 4
) (
	input logic clk,
	input logic rst,
	input isaPkg::instrWord instr,
	input logic [TagWidth-1:0] tag,
	input logic predictTaken,
	decodeFlagsIf.sink flags,
	output logic [TagWidth-1:0] decodedTag,
	output logic [2:0] length,
	output logic [ConstWidth-1:0] constant,
	output logic flowCtrl,
	output logic branch,
	output logic branchTaken,
	output logic jmp,
	output logic alu,
	output logic alu0Only,
	output logic fpu,
	output logic sync,
	output logic load,
	output logic mem,
	output logic memNdx,
	output logic rmw,
	output logic aq,
	output logic rl,
	output logic memdb,
	output logic memsb,
	output logic rfw,
	output logic preload,
	output logic [decodePkg::LaneCount-1:0] laneWe
);

	logic [2:0] lengthNext;
	logic [ConstWidth-1:0] constNext;
	logic signed [29:0] longImm;
	logic signed [13:0] shortImm;

	// ==============================
	// Length and constant
	// ==============================
	always_comb
	begin
		case (instr.i.len)
			decodePkg::LenCode4: lengthNext = decodePkg::Len4;
			decodePkg::LenCode6: lengthNext = decodePkg::Len6;
			default: lengthNext = decodePkg::Len2;
		endcase
	end

	assign longImm = {instr.i.immHi, instr.i.immLo};
	assign shortImm = instr.i.immLo;
	// Signed casts sign-extend to the full constant width
	assign constNext = (instr.i.len == decodePkg::LenCode6) ? ConstWidth'(longImm)
		: ConstWidth'(shortImm);

	// ==============================
	// Output register
	// ==============================
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			decodedTag <= '0;
			length <= '0;
			constant <= '0;
			flowCtrl <= 1'b0;
			branch <= 1'b0;
			branchTaken <= 1'b0;
			jmp <= 1'b0;
			alu <= 1'b0;
			alu0Only <= 1'b0;
			fpu <= 1'b0;
			sync <= 1'b0;
			load <= 1'b0;
			mem <= 1'b0;
			memNdx <= 1'b0;
			rmw <= 1'b0;
			aq <= 1'b0;
			rl <= 1'b0;
			memdb <= 1'b0;
			memsb <= 1'b0;
			rfw <= 1'b0;
			preload <= 1'b0;
			laneWe <= '0;
		end
		else
		begin
			decodedTag <= tag;
			length <= lengthNext;
			constant <= constNext;
			flowCtrl <= flags.flowCtrl;
			branch <= flags.branch;
			branchTaken <= flags.branch && predictTaken;
			jmp <= flags.jmp;
			alu <= flags.alu;
			alu0Only <= flags.alu0Only;
			fpu <= flags.fpu;
			sync <= flags.sync;
			load <= flags.load;
			mem <= flags.mem;
			memNdx <= flags.memNdx;
			rmw <= flags.rmw;
			aq <= flags.aq;
			rl <= flags.rl;
			memdb <= flags.memdb;
			memsb <= flags.memsb;
			rfw <= flags.rfw;
			preload <= flags.preload;
			laneWe <= flags.laneWe;
		end
	end

	// Once a real word has been registered some lane is always enabled
	assert property (@(posedge clk) disable iff (rst) !$past(rst) |-> laneWe != '0)
	else
		$error("laneWe is zero after reset, tag %h", decodedTag);

endmodule

// File: hw/decodePkg.sv
// Encodings of the decoded result only; lane masks assume eight byte lanes
package decodePkg;

	// Length codes from instruction bits 7:6
	localparam logic [1:0] LenCode4 = 2'd0;
	localparam logic [1:0] LenCode6 = 2'd1;

	// Instruction length in bytes
	localparam logic [2:0] Len2 = 3'd2;
	localparam logic [2:0] Len4 = 3'd4;
	localparam logic [2:0] Len6 = 3'd6;

	// ==============================
	// Register lanes
	// ==============================
	localparam int LaneCount = 8;

	localparam logic [LaneCount-1:0] LaneMask1   = 8'h01;
	localparam logic [LaneCount-1:0] LaneMask2   = 8'h03;
	localparam logic [LaneCount-1:0] LaneMask4   = 8'h0F;
	localparam logic [LaneCount-1:0] LaneMaskAll = 8'hFF;

endpackage

// File: hw/instrClassify.sv
// Combinational only; alu0Only depends on memNdx coming from the memory classifier
`timescale 1ns/1ps

module instrClassify (
	input isaPkg::instrWord instr,
	decodeFlagsIf.classSrc flags
);

	logic isR2;
	logic isRti;
	logic isFlow;
	logic isBranch;
	logic isFpu;
	logic isAlu;

	// ==============================
	// Unit and flow classes
	// ==============================
	always_comb
	begin
		isR2 = instr.r.opcode == isaPkg::OpR2;
		isRti = isR2 && instr.r.fn == isaPkg::FnRti;

		case (instr.r.opcode)
			isaPkg::OpBrk,
			isaPkg::OpBcc,
			isaPkg::OpBeqi,
			isaPkg::OpJmp,
			isaPkg::OpJal,
			isaPkg::OpCall,
			isaPkg::OpRet:
				isFlow = 1'b1;
			default:
				isFlow = isRti;
		endcase

		// Predictable branches only
		isBranch = instr.r.opcode == isaPkg::OpBcc || instr.r.opcode == isaPkg::OpBeqi;
		isFpu = instr.r.opcode == isaPkg::OpFloat;
		// Whatever the FPU and the sequencer leave goes to an ALU
		isAlu = !isFpu && !isFlow;

		assert (!isBranch || isFlow)
		else
			$error("branch decoded without flowCtrl, opcode %h", instr.r.opcode);
	end

	assign flags.flowCtrl = isFlow;
	assign flags.branch = isBranch;
	assign flags.jmp = instr.r.opcode == isaPkg::OpJmp;
	assign flags.fpu = isFpu;
	assign flags.alu = isAlu;

	// Multiply and every indexed access need the ALU0 address and multiplier path
	assign flags.alu0Only = instr.r.opcode == isaPkg::OpMuli
		|| (isR2 && instr.r.fn == isaPkg::FnMul)
		|| flags.memNdx;

	// Serialising forms
	assign flags.sync = instr.r.opcode == isaPkg::OpBrk
		|| isRti
		|| (isR2 && instr.r.fn == isaPkg::FnR1 && instr.r.rb == isaPkg::SubSync);

endmodule

// File: hw/instrDecoder.sv
// Latency of exactly one cycle and no back-pressure; ConstWidth must be at least 30
`timescale 1ns/1ps

module instrDecoder #(
	parameter int ConstWidth = 64,
	parameter int TagWidth = 4
) (
	input logic clk,
	input logic rst,
	input logic [47:0] instr,
	input logic [TagWidth-1:0] tag,
	input logic predictTaken,
	output logic [TagWidth-1:0] decodedTag,
	output logic [2:0] length,
	output logic [ConstWidth-1:0] constant,
	output logic flowCtrl,
	output logic branch,
	output logic branchTaken,
	output logic jmp,
	output logic alu,
	output logic alu0Only,
	output logic fpu,
	output logic sync,
	output logic load,
	output logic mem,
	output logic memNdx,
	output logic rmw,
	output logic aq,
	output logic rl,
	output logic memdb,
	output logic memsb,
	output logic rfw,
	output logic preload,
	output logic [decodePkg::LaneCount-1:0] laneWe
);

	decodeFlagsIf flagsBus ();

	// Combinational classifiers
	instrClassify classify (.instr(instr), .flags(flagsBus.classSrc));
	memClassify memClass (.instr(instr), .flags(flagsBus.memSrc));
	regWriteDecode regWrite (.instr(instr), .flags(flagsBus.regSrc));

	decodeOutputReg #(
		.ConstWidth(ConstWidth),
		.TagWidth(TagWidth)
	) outReg (
		.clk(clk),
		.rst(rst),
		.instr(instr),
		.tag(tag),
		.predictTaken(predictTaken),
		.flags(flagsBus.sink),
		.decodedTag(decodedTag),
		.length(length),
		.constant(constant),
		.flowCtrl(flowCtrl),
		.branch(branch),
		.branchTaken(branchTaken),
		.jmp(jmp),
		.alu(alu),
		.alu0Only(alu0Only),
		.fpu(fpu),
		.sync(sync),
		.load(load),
		.mem(mem),
		.memNdx(memNdx),
		.rmw(rmw),
		.aq(aq),
		.rl(rl),
		.memdb(memdb),
		.memsb(memsb),
		.rfw(rfw),
		.preload(preload),
		.laneWe(laneWe)
	);

endmodule

// File: hw/isaPkg.sv
// Opcode map local to this decoder; no vector or float-vector opcodes, unlisted opcodes are plain ALU ops
package isaPkg;

	// ==============================
	// Major opcodes
	// ==============================
	localparam logic [5:0] OpBrk   = 6'h00;
	localparam logic [5:0] OpR2    = 6'h02;
	localparam logic [5:0] OpAddi  = 6'h04;
	localparam logic [5:0] OpMuli  = 6'h06;
	localparam logic [5:0] OpAndi  = 6'h08;
	localparam logic [5:0] OpOri   = 6'h09;
	localparam logic [5:0] OpFloat = 6'h0F;
	localparam logic [5:0] OpLb    = 6'h13;
	localparam logic [5:0] OpSb    = 6'h15;
	localparam logic [5:0] OpJal   = 6'h18;
	localparam logic [5:0] OpCall  = 6'h19;
	localparam logic [5:0] OpInc   = 6'h1A;
	localparam logic [5:0] OpLw    = 6'h20;
	localparam logic [5:0] OpSw    = 6'h24;
	localparam logic [5:0] OpJmp   = 6'h28;
	localparam logic [5:0] OpRet   = 6'h29;
	localparam logic [5:0] OpCas   = 6'h2C;
	localparam logic [5:0] OpAmo   = 6'h2E;
	localparam logic [5:0] OpBcc   = 6'h30;
	localparam logic [5:0] OpBeqi  = 6'h32;

	// ==============================
	// R2 function codes
	// ==============================
	localparam logic [5:0] FnR1   = 6'h01;
	localparam logic [5:0] FnAdd  = 6'h04;
	localparam logic [5:0] FnSub  = 6'h05;
	localparam logic [5:0] FnAnd  = 6'h08;
	localparam logic [5:0] FnLbx  = 6'h13;
	localparam logic [5:0] FnSbx  = 6'h15;
	localparam logic [5:0] FnSwcx = 6'h17;
	localparam logic [5:0] FnLwrx = 6'h1D;
	localparam logic [5:0] FnLwx  = 6'h20;
	localparam logic [5:0] FnSwx  = 6'h24;
	localparam logic [5:0] FnCasx = 6'h2C;
	localparam logic [5:0] FnRti  = 6'h32;
	localparam logic [5:0] FnMul  = 6'h3A;

	// R1 sub-functions, carried in the Rb field
	localparam logic [4:0] SubMemdb = 5'h10;
	localparam logic [4:0] SubMemsb = 5'h11;
	localparam logic [4:0] SubSync  = 5'h12;

	// Two views of the same 48-bit word; opcode, length code, Ra and Rt line up in both
	typedef union packed {
		struct packed {
			logic [15:0] spare;
			logic [5:0]  fn;
			// Bit 2 doubles as acquire, bit 1 as release on ordered accesses
			logic [2:0]  sz;
			logic [4:0]  rb;
			logic [4:0]  rt;
			logic [4:0]  ra;
			logic [1:0]  len;
			logic [5:0]  opcode;
		} r;
		struct packed {
			// Upper part of the long immediate
			logic [15:0] immHi;
			// Short immediate, also the low part of the long one
			logic [13:0] immLo;
			logic [4:0]  rt;
			logic [4:0]  ra;
			logic [1:0]  len;
			logic [5:0]  opcode;
		} i;
	} instrWord;

endpackage

// File: hw/memClassify.sv
// Combinational only; acquire and release exist only on AMO and the indexed LWR and SWC forms
`timescale 1ns/1ps

module memClassify (
	input isaPkg::instrWord instr,
	decodeFlagsIf.memSrc flags
);

	logic isR2;
	logic isLoad;
	logic isNdx;
	logic isMem;
	logic isRmw;
	logic isOrdered;
	logic isBarrier;

	// ==============================
	// Access class
	// ==============================
	always_comb
	begin
		isR2 = instr.r.opcode == isaPkg::OpR2;
		isLoad = 1'b0;
		isNdx = 1'b0;

		if (isR2)
		begin
			case (instr.r.fn)
				isaPkg::FnLbx,
				isaPkg::FnLwx,
				isaPkg::FnLwrx:
				begin
					isLoad = 1'b1;
					isNdx = 1'b1;
				end
				isaPkg::FnSbx,
				isaPkg::FnSwx,
				isaPkg::FnSwcx,
				isaPkg::FnCasx:
					isNdx = 1'b1;
				default:
					isNdx = 1'b0;
			endcase
		end
		else
			isLoad = instr.r.opcode == isaPkg::OpLb || instr.r.opcode == isaPkg::OpLw;

		case (instr.r.opcode)
			isaPkg::OpSb,
			isaPkg::OpSw,
			isaPkg::OpCas,
			isaPkg::OpAmo,
			isaPkg::OpInc:
				isMem = 1'b1;
			default:
				isMem = isLoad || isNdx;
		endcase

		// Atomic read-modify-write forms
		isRmw = instr.r.opcode == isaPkg::OpCas
			|| instr.r.opcode == isaPkg::OpAmo
			|| instr.r.opcode == isaPkg::OpInc
			|| (isR2 && instr.r.fn == isaPkg::FnCasx);
	end

	// ==============================
	// Ordering and barriers
	// ==============================
	assign isOrdered = instr.r.opcode == isaPkg::OpAmo
		|| (isR2 && (instr.r.fn == isaPkg::FnLwrx || instr.r.fn == isaPkg::FnSwcx));

	// R1 with a barrier sub-function in Rb
	assign isBarrier = isR2 && instr.r.fn == isaPkg::FnR1;

	assign flags.load = isLoad;
	assign flags.memNdx = isNdx;
	assign flags.mem = isMem;
	assign flags.rmw = isRmw;
	assign flags.aq = isOrdered && instr.r.sz[2];
	assign flags.rl = isOrdered && instr.r.sz[1];
	assign flags.memdb = isBarrier && instr.r.rb == isaPkg::SubMemdb;
	assign flags.memsb = isBarrier && instr.r.rb == isaPkg::SubMemsb;

endmodule

// File: hw/regWriteDecode.sv
// Combinational only; target register is Rt of the word itself and Rt of zero never writes
`timescale 1ns/1ps

module regWriteDecode (
	input isaPkg::instrWord instr,
	decodeFlagsIf.regSrc flags
);

	logic isR2;
	logic rtZero;
	logic writes;
	logic rfw;
	logic preload;
	logic [decodePkg::LaneCount-1:0] laneWe;

	always_comb
	begin
		isR2 = instr.r.opcode == isaPkg::OpR2;
		rtZero = instr.r.rt == 5'd0;
		laneWe = decodePkg::LaneMaskAll;

		// Instructions that produce a register result
		if (isR2)
		begin
			case (instr.r.fn)
				isaPkg::FnR1,
				isaPkg::FnLbx,
				isaPkg::FnLwx,
				isaPkg::FnLwrx,
				isaPkg::FnCasx:
					writes = 1'b1;
				isaPkg::FnAdd,
				isaPkg::FnSub,
				isaPkg::FnAnd,
				isaPkg::FnMul:
				begin
					writes = 1'b1;
					// Sized ops only touch the low lanes
					case (instr.r.sz)
						3'd0: laneWe = decodePkg::LaneMask1;
						3'd1: laneWe = decodePkg::LaneMask2;
						3'd2: laneWe = decodePkg::LaneMask4;
						default: laneWe = decodePkg::LaneMaskAll;
					endcase
				end
				default:
					writes = 1'b0;
			endcase
		end
		else
		begin
			case (instr.r.opcode)
				isaPkg::OpAddi, isaPkg::OpAndi, isaPkg::OpOri, isaPkg::OpMuli,
				isaPkg::OpJal, isaPkg::OpCall, isaPkg::OpRet,
				isaPkg::OpLb, isaPkg::OpLw, isaPkg::OpCas, isaPkg::OpAmo:
					writes = 1'b1;
				default:
					writes = 1'b0;
			endcase
		end

		rfw = writes && !rtZero;
		// A load into r0 only warms the cache
		preload = flags.load && rtZero;
	end

	assign flags.rfw = rfw;
	assign flags.preload = preload;
	assign flags.laneWe = laneWe;

endmodule

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tbDecoder -f tb.f -o simDecoder
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit $status
fi

./obj_dir/simDecoder
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation failed with status $status"
	exit $status
fi

exit 0

// File: sim/tbDecoder.sv
// Checks every output one cycle after its word; reference rules assume ConstWidth 64 and eight lanes
`timescale 1ns/1ps

module tbDecoder;

	localparam int ConstWidth = 64;
	localparam int TagWidth = 4;
	localparam int ClkPeriod = 8;
	localparam int ResetCycles = 10;
	localparam int NumWords = 4000;
	localparam int Seed = 88990;

	localparam logic [5:0] OpList [0:19] = '{
		isaPkg::OpBrk, isaPkg::OpR2, isaPkg::OpAddi, isaPkg::OpMuli, isaPkg::OpAndi,
		isaPkg::OpOri, isaPkg::OpFloat, isaPkg::OpLb, isaPkg::OpSb, isaPkg::OpJal,
		isaPkg::OpCall, isaPkg::OpInc, isaPkg::OpLw, isaPkg::OpSw, isaPkg::OpJmp,
		isaPkg::OpRet, isaPkg::OpAmo, isaPkg::OpBcc, isaPkg::OpBeqi, isaPkg::OpCas
	};
	localparam logic [5:0] FnList [0:12] = '{
		isaPkg::FnR1, isaPkg::FnAdd, isaPkg::FnSub, isaPkg::FnAnd, isaPkg::FnLbx,
		isaPkg::FnSbx, isaPkg::FnSwcx, isaPkg::FnLwrx, isaPkg::FnLwx, isaPkg::FnSwx,
		isaPkg::FnCasx, isaPkg::FnRti, isaPkg::FnMul
	};

	logic clk = 1'b0;
	logic rst;
	logic [47:0] instr;
	logic [TagWidth-1:0] tag;
	logic predictTaken;
	logic [TagWidth-1:0] decodedTag;
	logic [2:0] length;
	logic [ConstWidth-1:0] constant;
	logic flowCtrl, branch, branchTaken, jmp, alu, alu0Only, fpu, sync;
	logic load, mem, memNdx, rmw, aq, rl, memdb, memsb;
	logic rfw, preload;
	logic [7:0] laneWe;

	// Output groups in the same bit order as the rule functions
	logic [7:0] classOut;
	logic [7:0] memOut;
	logic [9:0] regOut;

	logic [TagWidth-1:0] tagExp, tagPrev;
	logic [2:0] lenExp, lenPrev;
	logic [ConstWidth-1:0] constExp, constPrev;
	logic [7:0] classExp, classPrev;
	logic [7:0] memExp, memPrev;
	logic [9:0] regExp, regPrev;
	logic checkEn = 1'b0;

	instrDecoder #(
		.ConstWidth(ConstWidth),
		.TagWidth(TagWidth)
	) DUT (
		.clk(clk), .rst(rst), .instr(instr), .tag(tag), .predictTaken(predictTaken),
		.decodedTag(decodedTag), .length(length), .constant(constant),
		.flowCtrl(flowCtrl), .branch(branch), .branchTaken(branchTaken), .jmp(jmp),
		.alu(alu), .alu0Only(alu0Only), .fpu(fpu), .sync(sync),
		.load(load), .mem(mem), .memNdx(memNdx), .rmw(rmw), .aq(aq), .rl(rl),
		.memdb(memdb), .memsb(memsb), .rfw(rfw), .preload(preload), .laneWe(laneWe)
	);

	always #(ClkPeriod / 2) clk = ~clk;

	assign classOut = {flowCtrl, branch, branchTaken, jmp, alu, alu0Only, fpu, sync};
	assign memOut = {load, mem, memNdx, rmw, aq, rl, memdb, memsb};
	assign regOut = {rfw, preload, laneWe};

	// ==============================
	// Reference rules
	// ==============================
	function automatic logic r2With(input logic [47:0] w, input logic [5:0] fn);
		return (w[5:0] == isaPkg::OpR2) && (w[31:26] == fn);
	endfunction

	function automatic logic [2:0] lengthRule(input logic [47:0] w);
		case (w[7:6])
			decodePkg::LenCode4: return decodePkg::Len4;
			decodePkg::LenCode6: return decodePkg::Len6;
			default: return decodePkg::Len2;
		endcase
	endfunction

	function automatic logic [ConstWidth-1:0] constRule(input logic [47:0] w);
		if (w[7:6] == decodePkg::LenCode6)
			return {{(ConstWidth - 30){w[47]}}, w[47:18]};
		return {{(ConstWidth - 14){w[31]}}, w[31:18]};
	endfunction

	// {load, mem, memNdx, rmw, aq, rl, memdb, memsb}
	function automatic logic [7:0] memRule(input logic [47:0] w);
		logic [5:0] op;
		logic isLoad, isNdx, isMem, isRmw, ordered;
		op = w[5:0];
		isLoad = op == isaPkg::OpLb || op == isaPkg::OpLw || r2With(w, isaPkg::FnLbx)
			|| r2With(w, isaPkg::FnLwx) || r2With(w, isaPkg::FnLwrx);
		isNdx = r2With(w, isaPkg::FnLbx) || r2With(w, isaPkg::FnLwx) || r2With(w, isaPkg::FnLwrx)
			|| r2With(w, isaPkg::FnSbx) || r2With(w, isaPkg::FnSwx)
			|| r2With(w, isaPkg::FnSwcx) || r2With(w, isaPkg::FnCasx);
		isMem = isLoad || isNdx || op == isaPkg::OpSb || op == isaPkg::OpSw
			|| op == isaPkg::OpCas || op == isaPkg::OpAmo || op == isaPkg::OpInc;
		isRmw = op == isaPkg::OpCas || op == isaPkg::OpAmo || op == isaPkg::OpInc
			|| r2With(w, isaPkg::FnCasx);
		ordered = op == isaPkg::OpAmo || r2With(w, isaPkg::FnLwrx) || r2With(w, isaPkg::FnSwcx);
		return {isLoad, isMem, isNdx, isRmw, ordered && w[25], ordered && w[24],
			r2With(w, isaPkg::FnR1) && w[22:18] == isaPkg::SubMemdb,
			r2With(w, isaPkg::FnR1) && w[22:18] == isaPkg::SubMemsb};
	endfunction

	// {flowCtrl, branch, branchTaken, jmp, alu, alu0Only, fpu, sync}
	function automatic logic [7:0] classRule(input logic [47:0] w, input logic taken);
		logic [5:0] op;
		logic [7:0] memBits;
		logic flow, br, isFpu, alu0, isSync;
		op = w[5:0];
		memBits = memRule(w);
		flow = op == isaPkg::OpBrk || op == isaPkg::OpBcc || op == isaPkg::OpBeqi
			|| op == isaPkg::OpJmp || op == isaPkg::OpJal || op == isaPkg::OpCall
			|| op == isaPkg::OpRet || r2With(w, isaPkg::FnRti);
		br = op == isaPkg::OpBcc || op == isaPkg::OpBeqi;
		isFpu = op == isaPkg::OpFloat;
		alu0 = op == isaPkg::OpMuli || r2With(w, isaPkg::FnMul) || memBits[5];
		isSync = op == isaPkg::OpBrk || r2With(w, isaPkg::FnRti)
			|| (r2With(w, isaPkg::FnR1) && w[22:18] == isaPkg::SubSync);
		return {flow, br, br && taken, op == isaPkg::OpJmp, !isFpu && !flow, alu0, isFpu, isSync};
	endfunction

	// {rfw, preload, laneWe}
	function automatic logic [9:0] regRule(input logic [47:0] w);
		logic [5:0] op;
		logic [7:0] memBits;
		logic [7:0] lanes;
		logic sized, writes, rtZero;
		op = w[5:0];
		memBits = memRule(w);
		rtZero = w[17:13] == 5'd0;
		sized = r2With(w, isaPkg::FnAdd) || r2With(w, isaPkg::FnSub)
			|| r2With(w, isaPkg::FnAnd) || r2With(w, isaPkg::FnMul);
		writes = sized || r2With(w, isaPkg::FnR1) || r2With(w, isaPkg::FnLbx)
			|| r2With(w, isaPkg::FnLwx) || r2With(w, isaPkg::FnLwrx) || r2With(w, isaPkg::FnCasx)
			|| op == isaPkg::OpAddi || op == isaPkg::OpAndi || op == isaPkg::OpOri
			|| op == isaPkg::OpMuli || op == isaPkg::OpJal || op == isaPkg::OpCall
			|| op == isaPkg::OpRet || op == isaPkg::OpLb || op == isaPkg::OpLw
			|| op == isaPkg::OpCas || op == isaPkg::OpAmo;
		lanes = decodePkg::LaneMaskAll;
		if (sized)
		begin
			case (w[25:23])
				3'd0: lanes = decodePkg::LaneMask1;
				3'd1: lanes = decodePkg::LaneMask2;
				3'd2: lanes = decodePkg::LaneMask4;
				default: lanes = decodePkg::LaneMaskAll;
			endcase
		end
		return {writes && !rtZero, memBits[7] && rtZero, lanes};
	endfunction

	// Mostly listed opcodes with R2 weighted up, random fields elsewhere
	function automatic logic [47:0] makeWord();
		logic [47:0] w;
		logic [4:0] opIdx;
		logic [3:0] fnIdx;
		int pick;
		w[47:32] = 16'($urandom());
		w[31:0] = $urandom();
		pick = $urandom_range(0, 99);
		opIdx = 5'($urandom_range(0, 19));
		fnIdx = 4'($urandom_range(0, 12));
		if (pick < 8)
			w[5:0] = 6'($urandom());
		else if (pick < 45)
			w[5:0] = isaPkg::OpR2;
		else
			w[5:0] = OpList[opIdx];
		if ($urandom_range(0, 9) < 8)
			w[31:26] = FnList[fnIdx];
		// Barrier and sync sub-functions in Rb
		if ($urandom_range(0, 2) == 0)
			w[22:18] = isaPkg::SubMemdb + 5'($urandom_range(0, 2));
		if ($urandom_range(0, 3) == 0)
			w[17:13] = 5'd0;
		return w;
	endfunction

	// ==============================
	// Expected values, one cycle behind
	// ==============================
	always_comb
	begin
		tagExp = rst ? '0 : tag;
		lenExp = rst ? 3'd0 : lengthRule(instr);
		constExp = rst ? '0 : constRule(instr);
		classExp = rst ? 8'd0 : classRule(instr, predictTaken);
		memExp = rst ? 8'd0 : memRule(instr);
		regExp = rst ? 10'd0 : regRule(instr);
	end

	always @(posedge clk)
	begin
		tagPrev <= tagExp;
		lenPrev <= lenExp;
		constPrev <= constExp;
		classPrev <= classExp;
		memPrev <= memExp;
		regPrev <= regExp;
		checkEn <= 1'b1;
	end

	task automatic reportMismatch(input string name, input logic [63:0] got,
		input logic [63:0] want);
		$display("MISMATCH %s got %h expected %h", name, got, want);
		$display("Test FAILED");
		$fatal(1, "output check failed");
	endtask

	assert property (@(posedge clk) checkEn |-> decodedTag == tagPrev)
	else
		reportMismatch("decodedTag", 64'($sampled(decodedTag)), 64'($sampled(tagPrev)));
	assert property (@(posedge clk) checkEn |-> length == lenPrev)
	else
		reportMismatch("length", 64'($sampled(length)), 64'($sampled(lenPrev)));
	assert property (@(posedge clk) checkEn |-> constant == constPrev)
	else
		reportMismatch("constant", 64'($sampled(constant)), 64'($sampled(constPrev)));
	assert property (@(posedge clk) checkEn |-> classOut == classPrev)
	else
		reportMismatch("classFlags", 64'($sampled(classOut)), 64'($sampled(classPrev)));
	assert property (@(posedge clk) checkEn |-> memOut == memPrev)
	else
		reportMismatch("memFlags", 64'($sampled(memOut)), 64'($sampled(memPrev)));
	assert property (@(posedge clk) checkEn |-> regOut == regPrev)
	else
		reportMismatch("regWrite", 64'($sampled(regOut)), 64'($sampled(regPrev)));

	// ==============================
	// Stimulus and watchdog
	// ==============================
	initial
	begin
		rst = 1'b1;
		instr = '0;
		tag = '0;
		predictTaken = 1'b0;
		void'($urandom(Seed));
		repeat (ResetCycles) @(posedge clk);
		rst <= 1'b0;
		repeat (NumWords)
		begin
			instr <= makeWord();
			tag <= TagWidth'($urandom());
			predictTaken <= 1'($urandom());
			@(posedge clk);
		end
		// Let the last word reach the outputs and be checked
		repeat (2) @(posedge clk);
		@(negedge clk);
		$display("Test OK");
		$finish;
	end

	initial
	begin
		#((NumWords + 100) * ClkPeriod);
		$display("Watchdog expired before all words were applied");
		$display("Test FAILED");
		$fatal(1, "timeout");
	end

endmodule

// File: tb.f
hw/isaPkg.sv
hw/decodePkg.sv
hw/decodeFlagsIf.sv
hw/instrClassify.sv
hw/memClassify.sv
hw/regWriteDecode.sv
hw/decodeOutputReg.sv
hw/instrDecoder.sv
sim/tbDecoder.sv
